// File: dv/dbus_assertions.sv
module dbus_assertions #(
    parameter int N_CORES = 4
) (
    input logic                       w_clk,
    input logic                       rst_i,
    input logic [N_CORES-1:0]         req_vec,
    input logic [N_CORES-1:0]         done_vec,
    input logic [N_CORES-1:0]         pend_valid,
    input logic                       sel_valid_a,
    input logic                       sel_valid_b,
    input logic [$clog2(N_CORES)-1:0] sel_a,
    input logic [$clog2(N_CORES)-1:0] sel_b
);

    timeunit 1ns;
    timeprecision 1ps;

    for (genvar c = 0; c < N_CORES; c++) begin : gen_core_chk
        // done one cycle after the slot was selected
        assert property (@(posedge w_clk) disable iff (rst_i)
            done_vec[c] |-> $past(pend_valid[c]) && req_vec[c])
            else $error("done on core %0d without a pending request", c);
    end

    assert property (@(posedge w_clk) disable iff (rst_i)
        (sel_valid_a && sel_valid_b) |-> (sel_a != sel_b))
        else $error("ports a and b serve the same core");

endmodule

bind dmem_arbiter dbus_assertions #(
    .N_CORES (N_CORES)
) u_dbus_assertions (
    .w_clk       (w_clk),
    .rst_i       (rst_i),
    .req_vec     (req_vec),
    .done_vec    (done_vec),
    .pend_valid  (pend_valid),
    .sel_valid_a (sel_valid_a),
    .sel_valid_b (sel_valid_b),
    .sel_a       (sel_a),
    .sel_b       (sel_b)
);

// File: dv/dbus_checker.sv
module dbus_checker #(
    parameter int N_CORES = 4
) (
    input logic                     w_clk,
    input logic                     rst_i,
    input logic [N_CORES-1:0]       req_i,
    input logic [N_CORES-1:0]       ack_i,
    input logic [N_CORES-1:0][31:0] rdata_i
);

    timeunit 1ns;
    timeprecision 1ps;

    string              name_q  [N_CORES];
    byte                op_q    [N_CORES];
    logic [31:0]        exp_q   [N_CORES];
    logic [31:0]        ref_q   [N_CORES];  // last counter value per core
    logic [31:0]        held_q  [N_CORES];  // rdata seen when ack rose
    bit                 armed_q [N_CORES];
    logic [N_CORES-1:0] ack_prev;
    int                 n_pass = 0;
    int                 n_fail = 0;

    task automatic arm(input int c, input string name, input byte op, input logic [31:0] exp);
        name_q[c]  = name;
        op_q[c]    = op;
        exp_q[c]   = exp;
        armed_q[c] = 1'b1;
    endtask

    task automatic check_ack(input int c);
        bit          ok;
        logic [31:0] data;
        data = rdata_i[c];
        ok   = 1'b1;
        if (!armed_q[c]) begin
            n_fail++;
            $display("core %0d got an ack without a request", c);
        end else begin
            case (op_q[c])
                "N": ref_q[c] = data;  // reference read only
                "G": begin
                    ok       = (data > ref_q[c]);
                    exp_q[c] = ref_q[c] + 1;  // smallest value that passes
                    ref_q[c] = data;
                end
                "E": begin
                    ok       = (data == ref_q[c]);
                    exp_q[c] = ref_q[c];
                end
                default: ok = (data == exp_q[c]);
            endcase
            if (ok) begin
                n_pass++;
                $display("PASS %s core %0d data %h", name_q[c], c, data);
            end else begin
                n_fail++;
                $display("MISMATCH %s expected %h actual %h", name_q[c], exp_q[c], data);
            end
            armed_q[c] = 1'b0;
        end
    endtask

    task automatic report();
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    endtask

    // negedge sampling keeps away from the DUT's edge
    always @(negedge w_clk) begin
        if (rst_i) begin
            ack_prev = '0;
        end else begin
            for (int c = 0; c < N_CORES; c++) begin
                if (ack_i[c] && !ack_prev[c]) begin
                    held_q[c] = rdata_i[c];
                    check_ack(c);
                end else if (ack_i[c] && rdata_i[c] !== held_q[c]) begin
                    n_fail++;
                    $display("core %0d changed rdata while ack was high", c);
                end else if (!ack_i[c] && ack_prev[c] && req_i[c]) begin
                    n_fail++;
                    $display("core %0d dropped ack while req was still high", c);
                end
            end
            ack_prev = ack_i;
        end
    end

endmodule

// File: dv/dbus_patterns.txt
# name group core op(W write, R read, N ref read, G greater, E equal) addr data strb exp
# all numbers after op are hex, steps of one group start together
strb_full    1  0 W 10000010 11223344 f 00000000
strb_part    2  0 W 10000010 aabbccdd 5 00000000
strb_read    3  0 R 10000010 00000000 0 11bb33dd
conc_wr0     4  0 W 10000100 a0000000 f 00000000
conc_wr1     4  1 W 10000104 a1111111 f 00000000
conc_wr2     4  2 W 10000108 a2222222 f 00000000
conc_wr3     4  3 W 1000010c a3333333 f 00000000
conc_rd0     5  0 R 10000100 00000000 0 a0000000
conc_rd1     5  1 R 10000104 00000000 0 a1111111
conc_rd2     5  2 R 10000108 00000000 0 a2222222
conc_rd3     5  3 R 1000010c 00000000 0 a3333333
share_wr     6  2 W 10000200 cafef00d f 00000000
share_rd     7  0 R 10000200 00000000 0 cafef00d
hart_0       8  0 R 40001000 00000000 0 00000000
hart_1       8  1 R 40001000 00000000 0 00000001
hart_2       8  2 R 40001000 00000000 0 00000002
hart_3       8  3 R 40001000 00000000 0 00000003
perf_clear   9  1 W 40000000 00000000 f 00000000
perf_zero   10  1 R 40000004 00000000 0 00000000
perf_run    11  1 W 40000000 00000001 f 00000000
perf_ref    12  1 N 40000004 00000000 0 00000000
perf_grow   13  1 G 40000004 00000000 0 00000000
perf_hold   14  1 W 40000000 00000002 f 00000000
perf_href   15  1 N 40000004 00000000 0 00000000
perf_held   16  1 E 40000004 00000000 0 00000000
unmap_rd    17  3 R 30000000 00000000 0 00000000
unmap_wr    18  3 W 30000010 deadbeef f 00000000
unmap_chk   19  3 R 10000010 00000000 0 11bb33dd

// File: dv/tb_dbus_complex.sv
module tb_dbus_complex;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CORES         = 4;
    localparam int MAX_STEPS       = 64;
    localparam int CYCLES_PER_STEP = 64;

    logic                    w_clk;
    logic                    rst_i;
    logic [N_CORES-1:0]      req;
    logic [N_CORES-1:0]      we;
    logic [N_CORES-1:0][31:0] addr;
    logic [N_CORES-1:0][31:0] wdata;
    logic [N_CORES-1:0][3:0] wstrb;
    logic [N_CORES-1:0]      ack;
    logic [N_CORES-1:0][31:0] rdata;

    // step table loaded from the pattern file
    string       s_name  [MAX_STEPS];
    int          s_group [MAX_STEPS];
    int          s_core  [MAX_STEPS];
    byte         s_op    [MAX_STEPS];
    logic [31:0] s_addr  [MAX_STEPS];
    logic [31:0] s_data  [MAX_STEPS];
    logic [3:0]  s_strb  [MAX_STEPS];
    logic [31:0] s_exp   [MAX_STEPS];
    int          n_steps;
    int          cur [N_CORES];  // step index per core, -1 when idle
    int          cycles;
    int          limit;

    dbus_complex #(
        .N_CORES    (N_CORES),
        .DMEM_WORDS (4096)
    ) u_dbus_complex (
        .w_clk   (w_clk),
        .rst_i   (rst_i),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .wstrb_i (wstrb),
        .ack_o   (ack),
        .rdata_o (rdata)
    );

    dbus_checker #(
        .N_CORES (N_CORES)
    ) u_dbus_checker (
        .w_clk   (w_clk),
        .rst_i   (rst_i),
        .req_i   (req),
        .ack_i   (ack),
        .rdata_i (rdata)
    );

    initial begin
        w_clk = 1'b0;
        forever #4 w_clk = ~w_clk;  // 8 ns period
    end

    always @(posedge w_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: no ack after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       op;
        int          grp;
        int          core;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        logic [31:0] e;
        n_steps = 0;
        fd = $fopen("dv/dbus_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open pattern file dv/dbus_patterns.txt");
        end else begin
            while (!$feof(fd) && n_steps < MAX_STEPS) begin
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %d %d %s %h %h %h %h", name, grp, core, op, a, d, s, e);
                if (n == 8 && name[0] != "#") begin  // comment lines never parse to 8 fields
                    s_name[n_steps]  = name;
                    s_group[n_steps] = grp;
                    s_core[n_steps]  = core;
                    s_op[n_steps]    = op[0];
                    s_addr[n_steps]  = a;
                    s_data[n_steps]  = d;
                    s_strb[n_steps]  = s;
                    s_exp[n_steps]   = e;
                    n_steps++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one four-phase transfer on core c
    task automatic drive_core(input int c);
        int k;
        int gap;
        int hold;
        if (cur[c] >= 0) begin
            k    = cur[c];
            gap  = $urandom % 3;
            hold = $urandom % 3;
            repeat (gap) @(posedge w_clk);
            @(posedge w_clk);
            #1;
            we[c]    = (s_op[k] == "W");
            addr[c]  = s_addr[k];
            wdata[c] = s_data[k];
            wstrb[c] = s_strb[k];
            u_dbus_checker.arm(c, s_name[k], s_op[k], s_exp[k]);
            req[c] = 1'b1;
            do begin
                @(posedge w_clk);
                #1;
            end while (!ack[c]);
            repeat (hold) begin  // back-pressure, req kept high after the ack
                @(posedge w_clk);
                #1;
            end
            req[c] = 1'b0;
            do begin
                @(posedge w_clk);
                #1;
            end while (ack[c]);
        end
    endtask

    initial begin
        int i;
        int g;
        void'($urandom(32'h232d38cb));
        rst_i  = 1'b1;
        req    = '0;
        we     = '0;
        addr   = '0;
        wdata  = '0;
        wstrb  = '0;
        cycles = 0;
        limit  = MAX_STEPS * CYCLES_PER_STEP;
        read_patterns();
        limit = (n_steps + 1) * CYCLES_PER_STEP;
        repeat (4) @(posedge w_clk);
        #1;
        rst_i = 1'b0;
        i = 0;
        while (i < n_steps) begin
            g = s_group[i];
            for (int c = 0; c < N_CORES; c++) begin
                cur[c] = -1;
            end
            while (i < n_steps && s_group[i] == g) begin  // whole group goes out at once
                cur[s_core[i]] = i;
                i++;
            end
            fork
                drive_core(0);
                drive_core(1);
                drive_core(2);
                drive_core(3);
            join
        end
        repeat (2) @(posedge w_clk);
        u_dbus_checker.report();
        if (u_dbus_checker.n_fail == 0 && n_steps > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dbus_complex \
    -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: src/bus_pkg.sv
package bus_pkg;

    // bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;

    // region map on address bits 30..28
    localparam logic [2:0] REGION_DMEM      = 3'b001;  // 0x1xxx_xxxx
    localparam logic [2:0] REGION_PERF_HART = 3'b100;  // 0x4xxx_xxxx

    // inside the perf/hart region, bit 12 picks the hart index
    localparam int unsigned HART_SEL_BIT = 12;

    typedef enum logic [1:0] {
        RGN_DMEM = 2'd0,
        RGN_PERF = 2'd1,
        RGN_HART = 2'd2,
        RGN_NONE = 2'd3
    } region_e;

    // control word of the cycle counter, 3 also means hold
    typedef enum logic [1:0] {
        CNT_CLEAR = 2'd0,
        CNT_RUN   = 2'd1,
        CNT_HOLD  = 2'd2
    } cnt_ctrl_e;

    typedef enum logic [1:0] {
        PS_IDLE = 2'd0,  // waiting for req_i
        PS_BUSY = 2'd1,  // access under way
        PS_ACK  = 2'd2   // ack shown until req_i drops
    } port_state_e;

endpackage

// File: src/core_port.sv
module core_port
    import bus_pkg::*;
#(
    parameter int unsigned HART_ID = 0
) (
    input  logic              w_clk,
    input  logic              rst_i,
    input  logic              req_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [STRB_W-1:0] wstrb_i,
    output logic              ack_o,
    output logic [DATA_W-1:0] rdata_o,
    dbus_if.port              dm
);

    port_state_e       state_q;
    region_e           region_d;
    region_e           region_q;
    logic              dm_req_q;
    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] resp_data;
    logic [DATA_W-1:0] perf_rdata;
    logic              perf_wr;
    logic              load_rdata;

    always_comb begin
        region_d = RGN_NONE;
        if (addr_i[30:28] == REGION_DMEM) begin
            region_d = RGN_DMEM;
        end else if (addr_i[30:28] == REGION_PERF_HART) begin
            region_d = addr_i[HART_SEL_BIT] ? RGN_HART : RGN_PERF;
        end
    end

    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            state_q  <= PS_IDLE;
            region_q <= RGN_NONE;
            dm_req_q <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            case (state_q)
                PS_IDLE: begin
                    if (req_i) begin
                        state_q  <= PS_BUSY;
                        region_q <= region_d;  // fixed for the whole request
                        dm_req_q <= (region_d == RGN_DMEM);
                    end
                end
                PS_BUSY: begin
                    if (region_q != RGN_DMEM) begin
                        state_q <= PS_ACK;  // ack raised on the next edge
                    end else if (dm.done) begin
                        state_q  <= PS_ACK;
                        dm_req_q <= 1'b0;
                        ack_q    <= 1'b1;
                    end
                end
                PS_ACK: begin
                    ack_q <= req_i;  // falls one cycle after req_i
                    if (!req_i) begin
                        state_q <= PS_IDLE;
                    end
                end
                default: begin
                    state_q <= PS_IDLE;
                end
            endcase
        end
    end

    // response source, writes always answer zero
    always_comb begin
        case (region_q)
            RGN_DMEM: resp_data = dm.rdata;
            RGN_PERF: resp_data = perf_rdata;
            RGN_HART: resp_data = DATA_W'(HART_ID);
            default:  resp_data = '0;
        endcase
        if (we_i) begin
            resp_data = '0;
        end
    end

    assign load_rdata = (state_q == PS_BUSY && region_q == RGN_DMEM && dm.done)
                      || (state_q == PS_ACK && !ack_q);

    always_ff @(posedge w_clk) begin
        if (load_rdata) begin
            rdata_q <= resp_data;
        end
    end

    assign perf_wr = (state_q == PS_BUSY) && (region_q == RGN_PERF) && we_i;

    perf_counter u_perf_counter (
        .w_clk    (w_clk),
        .rst_i    (rst_i),
        .wr_en_i  (perf_wr),
        .offset_i (addr_i[3:0]),
        .ctrl_i   (wdata_i[1:0]),
        .rdata_o  (perf_rdata)
    );

    // payload is stable while req_i is high
    assign dm.req   = dm_req_q;
    assign dm.we    = we_i;
    assign dm.addr  = addr_i;
    assign dm.wdata = wdata_i;
    assign dm.wstrb = wstrb_i;

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

endmodule

// File: src/dbus_complex.sv
module dbus_complex
    import bus_pkg::*;
#(
    parameter int unsigned N_CORES    = 4,
    parameter int unsigned DMEM_WORDS = 4096
) (
    input  logic                           w_clk,
    input  logic                           rst_i,
    input  logic [N_CORES-1:0]             req_i,
    input  logic [N_CORES-1:0]             we_i,
    input  logic [N_CORES-1:0][ADDR_W-1:0] addr_i,
    input  logic [N_CORES-1:0][DATA_W-1:0] wdata_i,
    input  logic [N_CORES-1:0][STRB_W-1:0] wstrb_i,
    output logic [N_CORES-1:0]             ack_o,
    output logic [N_CORES-1:0][DATA_W-1:0] rdata_o
);

    // one dmem link per core
    dbus_if dm_if [N_CORES] ();

    for (genvar c = 0; c < N_CORES; c++) begin : gen_core
        core_port #(
            .HART_ID (c)
        ) u_core_port (
            .w_clk   (w_clk),
            .rst_i   (rst_i),
            .req_i   (req_i[c]),
            .we_i    (we_i[c]),
            .addr_i  (addr_i[c]),
            .wdata_i (wdata_i[c]),
            .wstrb_i (wstrb_i[c]),
            .ack_o   (ack_o[c]),
            .rdata_o (rdata_o[c]),
            .dm      (dm_if[c])
        );
    end

    dmem_arbiter #(
        .N_CORES    (N_CORES),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem_arbiter (
        .w_clk (w_clk),
        .rst_i (rst_i),
        .cores (dm_if)
    );

endmodule

// File: src/dbus_if.sv
interface dbus_if
    import bus_pkg::*;
();

    logic              req;    // held until done
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              done;   // one-cycle pulse
    logic [DATA_W-1:0] rdata;  // valid with done

    modport port (
        output req, we, addr, wdata, wstrb,
        input  done, rdata
    );

    modport arb (
        input  req, we, addr, wdata, wstrb,
        output done, rdata
    );

endinterface

// File: src/dmem_arbiter.sv
module dmem_arbiter
    import bus_pkg::*;
#(
    parameter int unsigned N_CORES    = 4,
    parameter int unsigned DMEM_WORDS = 4096
) (
    input  logic w_clk,
    input  logic rst_i,
    dbus_if.arb  cores [N_CORES]
);

    localparam int unsigned IDX_W  = (N_CORES > 1) ? $clog2(N_CORES) : 1;
    localparam int unsigned WORD_W = $clog2(DMEM_WORDS);

    logic [N_CORES-1:0] req_vec;
    logic [N_CORES-1:0] req_we;
    logic [ADDR_W-1:0]  req_addr   [N_CORES];
    logic [DATA_W-1:0]  req_wdata  [N_CORES];
    logic [STRB_W-1:0]  req_wstrb  [N_CORES];
    logic [N_CORES-1:0] done_vec;

    logic [N_CORES-1:0] pend_valid;
    logic [N_CORES-1:0] pend_we;
    logic [WORD_W-1:0]  pend_addr  [N_CORES];
    logic [DATA_W-1:0]  pend_wdata [N_CORES];
    logic [STRB_W-1:0]  pend_wstrb [N_CORES];

    logic [IDX_W-1:0]   rr_ptr;
    logic [IDX_W-1:0]   sel_a;
    logic [IDX_W-1:0]   sel_b;
    logic               sel_valid_a;
    logic               sel_valid_b;
    logic [N_CORES-1:0] served;

    logic [IDX_W-1:0]   resp_core_a;
    logic [IDX_W-1:0]   resp_core_b;
    logic               resp_valid_a;
    logic               resp_valid_b;
    logic [DATA_W-1:0]  rdata_a;
    logic [DATA_W-1:0]  rdata_b;

    for (genvar c = 0; c < N_CORES; c++) begin : gen_core_if
        assign req_vec[c]   = cores[c].req;
        assign req_we[c]    = cores[c].we;
        assign req_addr[c]  = cores[c].addr;
        assign req_wdata[c] = cores[c].wdata;
        assign req_wstrb[c] = cores[c].wstrb;

        assign done_vec[c] = (resp_valid_a && resp_core_a == IDX_W'(c))
                           || (resp_valid_b && resp_core_b == IDX_W'(c));
        assign cores[c].done  = done_vec[c];
        assign cores[c].rdata = (resp_valid_a && resp_core_a == IDX_W'(c)) ? rdata_a : rdata_b;
    end

    // req stays high through done, so a finished request is not latched again
    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            pend_valid <= '0;
        end else begin
            for (int c = 0; c < N_CORES; c++) begin
                if (served[c]) begin
                    pend_valid[c] <= 1'b0;
                end else if (req_vec[c] && !pend_valid[c] && !done_vec[c]) begin
                    pend_valid[c] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge w_clk) begin
        for (int c = 0; c < N_CORES; c++) begin
            if (!pend_valid[c]) begin
                pend_we[c]    <= req_we[c];
                pend_addr[c]  <= req_addr[c][WORD_W+1:2];  // word index
                pend_wdata[c] <= req_wdata[c];
                pend_wstrb[c] <= req_wstrb[c];
            end
        end
    end

    // first two pending slots from rr_ptr onwards
    always_comb begin
        int unsigned idx;
        sel_a       = '0;
        sel_b       = '0;
        sel_valid_a = 1'b0;
        sel_valid_b = 1'b0;
        for (int k = 0; k < N_CORES; k++) begin
            idx = (int'(rr_ptr) + k) % N_CORES;
            if (pend_valid[idx]) begin
                if (!sel_valid_a) begin
                    sel_a       = IDX_W'(idx);
                    sel_valid_a = 1'b1;
                end else if (!sel_valid_b) begin
                    sel_b       = IDX_W'(idx);
                    sel_valid_b = 1'b1;
                end
            end
        end
        served = '0;
        if (sel_valid_a) begin
            served[sel_a] = 1'b1;
        end
        if (sel_valid_b) begin
            served[sel_b] = 1'b1;
        end
    end

    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            rr_ptr       <= '0;
            resp_valid_a <= 1'b0;
            resp_valid_b <= 1'b0;
        end else begin
            resp_valid_a <= sel_valid_a;
            resp_valid_b <= sel_valid_b;
            if (sel_valid_b) begin
                rr_ptr <= IDX_W'((int'(sel_b) + 1) % N_CORES);  // past the last one served
            end else if (sel_valid_a) begin
                rr_ptr <= IDX_W'((int'(sel_a) + 1) % N_CORES);
            end
        end
    end

    always_ff @(posedge w_clk) begin
        resp_core_a <= sel_a;
        resp_core_b <= sel_b;
    end

    dual_port_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dual_port_dmem (
        .w_clk     (w_clk),
        .we_a_i    (sel_valid_a && pend_we[sel_a]),
        .addr_a_i  (pend_addr[sel_a]),
        .wdata_a_i (pend_wdata[sel_a]),
        .wstrb_a_i (pend_wstrb[sel_a]),
        .rdata_a_o (rdata_a),
        .we_b_i    (sel_valid_b && pend_we[sel_b]),
        .addr_b_i  (pend_addr[sel_b]),
        .wdata_b_i (pend_wdata[sel_b]),
        .wstrb_b_i (pend_wstrb[sel_b]),
        .rdata_b_o (rdata_b)
    );

endmodule

// File: src/dual_port_dmem.sv
module dual_port_dmem
    import bus_pkg::*;
#(
    parameter int unsigned DMEM_WORDS = 4096
) (
    input  logic                          w_clk,
    input  logic                          we_a_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] addr_a_i,
    input  logic [DATA_W-1:0]             wdata_a_i,
    input  logic [STRB_W-1:0]             wstrb_a_i,
    output logic [DATA_W-1:0]             rdata_a_o,
    input  logic                          we_b_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] addr_b_i,
    input  logic [DATA_W-1:0]             wdata_b_i,
    input  logic [STRB_W-1:0]             wstrb_b_i,
    output logic [DATA_W-1:0]             rdata_b_o
);

    logic [DATA_W-1:0] mem [DMEM_WORDS] = '{default: '0};  // starts cleared

    // port b is written last, so its bytes win on a collision
    always_ff @(posedge w_clk) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (we_a_i && wstrb_a_i[b]) begin
                mem[addr_a_i][b*8 +: 8] <= wdata_a_i[b*8 +: 8];
            end
        end
        for (int b = 0; b < STRB_W; b++) begin
            if (we_b_i && wstrb_b_i[b]) begin
                mem[addr_b_i][b*8 +: 8] <= wdata_b_i[b*8 +: 8];
            end
        end
        rdata_a_o <= mem[addr_a_i];  // old data on a write
        rdata_b_o <= mem[addr_b_i];
    end

endmodule

// File: src/perf_counter.sv
module perf_counter
    import bus_pkg::*;
(
    input  logic              w_clk,
    input  logic              rst_i,
    input  logic              wr_en_i,
    input  logic [3:0]        offset_i,
    input  logic [1:0]        ctrl_i,
    output logic [DATA_W-1:0] rdata_o
);

    cnt_ctrl_e           ctrl_q;
    cnt_ctrl_e           ctrl_d;
    logic [2*DATA_W-1:0] mcycle;

    // both 2 and 3 map to hold
    assign ctrl_d = (ctrl_i == CNT_CLEAR) ? CNT_CLEAR :
                    (ctrl_i == CNT_RUN)   ? CNT_RUN   : CNT_HOLD;

    always_ff @(posedge w_clk) begin
        if (rst_i) begin
            ctrl_q <= CNT_CLEAR;
        end else if (wr_en_i && offset_i == 4'd0) begin
            ctrl_q <= ctrl_d;
        end
    end

    always_ff @(posedge w_clk) begin
        case (ctrl_q)
            CNT_CLEAR: mcycle <= '0;
            CNT_RUN:   mcycle <= mcycle + 1'b1;
            default:   mcycle <= mcycle;  // frozen
        endcase
        rdata_o <= (offset_i == 4'd4) ? mcycle[DATA_W-1:0] : mcycle[2*DATA_W-1:DATA_W];
    end

endmodule

// File: vlog.f
src/bus_pkg.sv
src/dbus_if.sv
src/perf_counter.sv
src/dual_port_dmem.sv
src/dmem_arbiter.sv
src/core_port.sv
src/dbus_complex.sv
dv/dbus_checker.sv
dv/dbus_assertions.sv
dv/tb_dbus_complex.sv
